/* files.f */
+incdir+include
hw/flight_pkg.sv
hw/pulse_pkg.sv
hw/us_tick.sv
hw/receiver.sv
hw/angle_controller.sv
hw/body_frame_controller.sv
hw/motor_mixer.sv
hw/pwm_generator.sv
hw/drone_core.sv
verification/drone_core_assertions.sv
verification/drone_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass message in the log

cd "$(dirname "$0")" || { echo "Cannot enter the project root"; exit 1; }

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module drone_core_tb \
	-f files.f -o drone_core_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $build_status"
	exit 1
fi

# Raise the error limit so a failed assertion does not stop the run early
./obj_dir/drone_core_sim +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Testbench passed" "$SIM_LOG"; then
	exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

/* verification/drone_core_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Needs CLK_PER_US of 10
// Widths are checked in the first frame after a done
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module drone_core_tb;

	localparam int FRAME_CYC = `PWM_FRAME_US * `CLK_PER_US;

	logic sys_clk;
	logic resetn;
	logic throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm; // RC receiver lines
	logic imu_valid;
	flight_pkg::imu_val_t euler_roll, euler_pitch;
	flight_pkg::imu_val_t gyro_roll, gyro_pitch, gyro_yaw;
	logic motor_1_pwm, motor_2_pwm, motor_3_pwm, motor_4_pwm;
	logic ctrl_done;

	int value_errors; // Failed width checks
	int timeouts;
	int assert_errors;
	int cur_us [4]; // Last RC widths sent in throttle yaw roll pitch order
	int high_cyc [4]; // High cycles of each motor in the measured frame
	logic [31:0] lfsr;

	drone_core u_dut (
		.sys_clk(sys_clk), .resetn(resetn),
		.throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm), .pitch_pwm(pitch_pwm),
		.imu_valid(imu_valid),
		.euler_roll(euler_roll), .euler_pitch(euler_pitch),
		.gyro_roll(gyro_roll), .gyro_pitch(gyro_pitch), .gyro_yaw(gyro_yaw),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm),
		.ctrl_done(ctrl_done));

	bind drone_core drone_core_assertions u_checks (
		.sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid), .ctrl_done(ctrl_done),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk; // 100 ns period
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic int rand_bits(input int n);
		int v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	function automatic int clamp(input int v, input int lo, input int hi);
		if (v < lo) return lo;
		if (v > hi) return hi;
		return v;
	endfunction

	function automatic int stick_of(input int us);
		return clamp((us - `RC_MIN_US) / 4, 0, 255);
	endfunction

	// Angle, rate and mixer rules on the current inputs give the width in us
	function automatic int expected_width(input int motor);
		int thr, yaw_r, roll_e, pitch_e, roll_r, pitch_r, mix;
		thr     = stick_of(cur_us[0]) * 4;
		roll_e  = stick_of(cur_us[2]) - `RC_CENTER - (int'(euler_roll) >>> 4);
		pitch_e = stick_of(cur_us[3]) - `RC_CENTER - (int'(euler_pitch) >>> 4);
		roll_e  = clamp(roll_e, -32768, 32767);
		pitch_e = clamp(pitch_e, -32768, 32767);
		roll_r  = clamp(roll_e <<< `ANGLE_GAIN_SHIFT, -32768, 32767) - (int'(gyro_roll) >>> 4);
		roll_r  = clamp(roll_r + (roll_e >>> 2), -2048, 2047);
		pitch_r = clamp(pitch_e <<< `ANGLE_GAIN_SHIFT, -32768, 32767) - (int'(gyro_pitch) >>> 4);
		pitch_r = clamp(pitch_r + (pitch_e >>> 2), -2048, 2047);
		yaw_r   = clamp((stick_of(cur_us[1]) - `RC_CENTER) <<< `YAW_GAIN_SHIFT, -32768, 32767);
		yaw_r   = clamp(yaw_r - (int'(gyro_yaw) >>> 4), -2048, 2047); // No angle term
		case (motor)
			1: mix = thr + pitch_r - roll_r - yaw_r; // Front right
			2: mix = thr - pitch_r + roll_r - yaw_r; // Rear left
			3: mix = thr + pitch_r + roll_r + yaw_r; // Front left
			default: mix = thr - pitch_r - roll_r + yaw_r; // Rear right
		endcase
		return `PWM_MIN_US + clamp(mix, 0, `MOTOR_MAX);
	endfunction

	// All four RC pulses start together and each drops after its own width
	task automatic send_sticks(input int thr_us, input int yaw_us, input int roll_us,
		input int pitch_us);
		int last_cyc;
		cur_us[0] = thr_us;
		cur_us[1] = yaw_us;
		cur_us[2] = roll_us;
		cur_us[3] = pitch_us;
		last_cyc  = thr_us;
		if (yaw_us > last_cyc) last_cyc = yaw_us;
		if (roll_us > last_cyc) last_cyc = roll_us;
		if (pitch_us > last_cyc) last_cyc = pitch_us;
		last_cyc = last_cyc * `CLK_PER_US;
		@(posedge sys_clk);
		#1;
		{throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm} = 4'b1111;
		for (int t = 1; t <= last_cyc; t++) begin
			@(posedge sys_clk);
			#1;
			if (t == thr_us * `CLK_PER_US) throttle_pwm = 1'b0;
			if (t == yaw_us * `CLK_PER_US) yaw_pwm = 1'b0;
			if (t == roll_us * `CLK_PER_US) roll_pwm = 1'b0;
			if (t == pitch_us * `CLK_PER_US) pitch_pwm = 1'b0;
		end
		repeat (4) @(posedge sys_clk); // Receiver lands 3 cycles after the fall
		#1;
	endtask

	// One imu_valid and optionally a second one while the angle stage is busy
	task automatic run_control(input logic second_strobe);
		@(posedge sys_clk);
		#1;
		imu_valid = 1'b1;
		@(posedge sys_clk);
		#1;
		imu_valid = 1'b0;
		if (second_strobe) begin
			@(posedge sys_clk);
			#1;
			imu_valid = 1'b1; // 2 cycles after the first
			@(posedge sys_clk);
			#1;
			imu_valid = 1'b0;
		end
		for (int n = 0; n < 32; n++) begin
			if (ctrl_done) break;
			@(posedge sys_clk);
			#1;
		end
		if (!ctrl_done) begin
			$display("Timeout: ctrl_done did not rise within 32 cycles of imu_valid");
			timeouts++;
		end
	endtask

	// Wait for a frame start on motor 1 and count high cycles on all four
	task automatic measure_frame();
		logic [3:0] pwm;
		logic [3:0] prev;
		logic started;
		@(posedge sys_clk); // Mixer output lands this cycle
		#1;
		prev    = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
		pwm     = prev;
		started = 1'b0;
		for (int n = 0; n < 2 * FRAME_CYC && !started; n++) begin
			@(posedge sys_clk);
			#1;
			pwm     = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
			started = pwm[0] && !prev[0];
			prev    = pwm;
		end
		if (!started) begin
			$display("Timeout: no frame start seen on motor_1_pwm within two frames");
			timeouts++;
		end
		for (int m = 0; m < 4; m++) high_cyc[m] = int'(pwm[m]);
		for (int n = 0; n < FRAME_CYC && pwm != 4'b0000; n++) begin
			@(posedge sys_clk);
			#1;
			pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
			for (int m = 0; m < 4; m++) high_cyc[m] += int'(pwm[m]);
		end
		if (pwm != 4'b0000) begin
			$display("Timeout: motor outputs stayed high for a whole frame");
			timeouts++;
		end
	endtask

	task automatic check_widths(input logic after_reset);
		int exp_cyc;
		for (int m = 0; m < 4; m++) begin
			exp_cyc = `PWM_MIN_US * `CLK_PER_US; // Commands are 0 out of reset
			if (!after_reset) exp_cyc = expected_width(m + 1) * `CLK_PER_US;
			assert (high_cyc[m] == exp_cyc) else begin
				$display("FAIL %0t: motor_%0d_pwm high cycles expected %0d, got %0d",
					$time, m + 1, exp_cyc, high_cyc[m]);
				value_errors++;
			end
		end
	endtask

	initial begin
		resetn       = 1'b0;
		throttle_pwm = 1'b0;
		yaw_pwm      = 1'b0;
		roll_pwm     = 1'b0;
		pitch_pwm    = 1'b0;
		imu_valid    = 1'b0;
		euler_roll   = '0;
		euler_pitch  = '0;
		gyro_roll    = '0;
		gyro_pitch   = '0;
		gyro_yaw     = '0;
		value_errors = 0;
		timeouts     = 0;
		lfsr         = 32'h43bd_3493;
		for (int i = 0; i < 4; i++) cur_us[i] = `RC_MIN_US;
		repeat (16) @(posedge sys_clk);
		#1;
		resetn = 1'b1;

		measure_frame(); // First frame runs on zero commands
		check_widths(1'b1);

		// Hover sticks with a second strobe while busy
		send_sticks(1500, 1512, 1512, 1512);
		run_control(1'b1);
		measure_frame();
		check_widths(1'b0);

		euler_roll = 16'sd160; // 10 degrees right
		run_control(1'b0);
		measure_frame();
		check_widths(1'b0);

		repeat (3) begin
			gyro_roll   = flight_pkg::imu_val_t'(rand_bits(14) - 8192);
			gyro_pitch  = flight_pkg::imu_val_t'(rand_bits(14) - 8192);
			gyro_yaw    = flight_pkg::imu_val_t'(rand_bits(14) - 8192);
			euler_pitch = flight_pkg::imu_val_t'(rand_bits(12) - 2048); // Up to 128 degrees
			run_control(1'b0);
			measure_frame();
			check_widths(1'b0);
		end

		// Full throttle and full left roll clamp motors 1 and 4
		euler_roll  = '0;
		euler_pitch = '0;
		gyro_roll   = '0;
		gyro_pitch  = '0;
		gyro_yaw    = '0;
		send_sticks(2000, 1512, 1000, 1512);
		run_control(1'b0);
		measure_frame();
		check_widths(1'b0);

		repeat (10) @(posedge sys_clk);
		#1;
		assert_errors = u_dut.u_checks.fail_count;
		$display("Summary: %0d width errors, %0d assertion errors, %0d timeouts",
			value_errors, assert_errors, timeouts);
		if (value_errors == 0 && assert_errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verification/drone_core_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// Sees top-level ports only, frame check assumes all commands give a pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module drone_core_assertions (
	input logic sys_clk,
	input logic resetn,
	input logic imu_valid,
	input logic ctrl_done,
	input logic motor_1_pwm,
	input logic motor_2_pwm,
	input logic motor_3_pwm,
	input logic motor_4_pwm
);

	localparam int FRAME_CYC = `PWM_FRAME_US * `CLK_PER_US; // ESC frame in sys_clk cycles

	int fail_count = 0; // Read by the testbench at the end
	logic [2:0] busy_cnt; // Cycles until the angle stage is idle again
	logic start_ok; // Strobe the angle stage takes
	logic [3:0] pwm;

	assign pwm      = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
	assign start_ok = imu_valid && (busy_cnt == 3'd0);

	// Angle stage walks roll, pitch, yaw, done before taking a new sample
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			busy_cnt <= 3'd0;
		end else if (start_ok) begin
			busy_cnt <= 3'd4;
		end else if (busy_cnt != 3'd0) begin
			busy_cnt <= busy_cnt - 3'd1;
		end
	end

	a_reset_quiet: assert property (@(posedge sys_clk) !resetn |=> (!ctrl_done && pwm == 4'b0000))
		else begin
			$error("FAIL %0t: ctrl_done or motor pwm expected 0 in reset, got %b %b",
				$time, $sampled(ctrl_done), $sampled(pwm));
			fail_count++;
		end

	a_latency: assert property (@(posedge sys_clk) disable iff (!resetn)
		start_ok |-> ##8 ctrl_done)
		else begin
			$error("FAIL %0t: ctrl_done expected 1 eight cycles after imu_valid, got 0", $time);
			fail_count++;
		end

	// Ignored strobes must not produce a done
	a_no_extra: assert property (@(posedge sys_clk) disable iff (!resetn)
		ctrl_done |-> $past(start_ok, 8))
		else begin
			$error("FAIL %0t: ctrl_done expected 0 with no accepted strobe, got 1", $time);
			fail_count++;
		end

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!resetn)
		ctrl_done |=> !ctrl_done)
		else begin
			$error("FAIL %0t: ctrl_done expected 0 after one cycle, got 1", $time);
			fail_count++;
		end

	for (genvar m = 0; m < 4; m++) begin : g_frame
		int since_rise; // Cycles since the last rising edge
		logic pwm_q;
		logic seen_rise; // First edge only starts the count
		logic rise;

		assign rise = pwm[m] && !pwm_q;

		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				since_rise <= 0;
				pwm_q      <= 1'b0;
				seen_rise  <= 1'b0;
			end else begin
				pwm_q <= pwm[m];
				if (rise) begin
					since_rise <= 1;
					seen_rise  <= 1'b1;
				end else if (since_rise < 2 * FRAME_CYC) begin
					since_rise <= since_rise + 1; // Stops well past a frame
				end
			end
		end

		a_frame: assert property (@(posedge sys_clk) disable iff (!resetn)
			(rise && seen_rise) |-> since_rise == FRAME_CYC)
			else begin
				$error("FAIL %0t: motor_%0d_pwm period expected %0d cycles, got %0d",
					$time, m + 1, FRAME_CYC, $sampled(since_rise));
				fail_count++;
			end
	end

endmodule

/* hw/drone_core.sv */
////////////////////////////////////////////////////////////////////////////
// IMU driver is external, imu_valid must be a single-cycle strobe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drone_core (
	input  logic                 sys_clk,
	input  logic                 resetn,
	input  logic                 throttle_pwm,
	input  logic                 yaw_pwm,
	input  logic                 roll_pwm,
	input  logic                 pitch_pwm,
	input  logic                 imu_valid,
	input  flight_pkg::imu_val_t euler_roll,
	input  flight_pkg::imu_val_t euler_pitch,
	input  flight_pkg::imu_val_t gyro_roll,
	input  flight_pkg::imu_val_t gyro_pitch,
	input  flight_pkg::imu_val_t gyro_yaw,
	output logic                 motor_1_pwm,
	output logic                 motor_2_pwm,
	output logic                 motor_3_pwm,
	output logic                 motor_4_pwm,
	output logic                 ctrl_done // Motor commands follow one cycle later
);

	logic us_en;
	flight_pkg::rc_val_t throttle_val, yaw_val, roll_val, pitch_val;
	flight_pkg::rate_t throttle_rate, roll_target, pitch_target, yaw_target;
	flight_pkg::rate_t roll_angle_error, pitch_angle_error;
	logic ac_done;
	flight_pkg::pid_rate_t roll_rate, pitch_rate, yaw_rate;
	logic bf_done;
	flight_pkg::motor_rate_t motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate;

	us_tick u_us_tick (.sys_clk(sys_clk), .resetn(resetn), .us_en(us_en));

	receiver u_receiver (
		.sys_clk(sys_clk), .resetn(resetn), .us_en(us_en),
		.throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm), .pitch_pwm(pitch_pwm),
		.throttle_val(throttle_val), .yaw_val(yaw_val),
		.roll_val(roll_val), .pitch_val(pitch_val));

	angle_controller u_angle_controller (
		.sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid),
		.throttle_val(throttle_val), .yaw_val(yaw_val),
		.roll_val(roll_val), .pitch_val(pitch_val),
		.euler_roll(euler_roll), .euler_pitch(euler_pitch),
		.throttle_rate(throttle_rate), .roll_target(roll_target),
		.pitch_target(pitch_target), .yaw_target(yaw_target),
		.roll_angle_error(roll_angle_error), .pitch_angle_error(pitch_angle_error),
		.ac_done(ac_done));

	body_frame_controller u_body_frame_controller (
		.sys_clk(sys_clk), .resetn(resetn), .ac_done(ac_done),
		.roll_target(roll_target), .pitch_target(pitch_target), .yaw_target(yaw_target),
		.roll_angle_error(roll_angle_error), .pitch_angle_error(pitch_angle_error),
		.gyro_roll(gyro_roll), .gyro_pitch(gyro_pitch), .gyro_yaw(gyro_yaw),
		.roll_rate(roll_rate), .pitch_rate(pitch_rate), .yaw_rate(yaw_rate),
		.bf_done(bf_done));

	motor_mixer u_motor_mixer (
		.sys_clk(sys_clk), .resetn(resetn), .bf_done(bf_done),
		.throttle_rate(throttle_rate), .roll_rate(roll_rate),
		.pitch_rate(pitch_rate), .yaw_rate(yaw_rate),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate));

	pwm_generator u_pwm_generator (
		.sys_clk(sys_clk), .resetn(resetn), .us_en(us_en),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

	assign ctrl_done = bf_done; // End of the control chain

endmodule

/* hw/pwm_generator.sv */
////////////////////////////////////////////////////////////////////////////
// Commands are sampled only at frame start, first frame on first us_en
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module pwm_generator (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    us_en,
	input  flight_pkg::motor_rate_t motor_1_rate,
	input  flight_pkg::motor_rate_t motor_2_rate,
	input  flight_pkg::motor_rate_t motor_3_rate,
	input  flight_pkg::motor_rate_t motor_4_rate,
	output logic                    motor_1_pwm,
	output logic                    motor_2_pwm,
	output logic                    motor_3_pwm,
	output logic                    motor_4_pwm
);

	pulse_pkg::pulse_us_t frame_cnt; // Position in the frame, in us
	pulse_pkg::pulse_us_t width_q [4]; // High time for this frame
	flight_pkg::motor_rate_t rate_in [4];
	logic frame_end;

	assign rate_in[0] = motor_1_rate;
	assign rate_in[1] = motor_2_rate;
	assign rate_in[2] = motor_3_rate;
	assign rate_in[3] = motor_4_rate;

	assign frame_end = (frame_cnt == 12'(`PWM_FRAME_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_cnt <= 12'(`PWM_FRAME_US - 1); // Next us_en opens a frame
			for (int i = 0; i < 4; i++) begin
				width_q[i] <= '0; // Outputs low until the first frame
			end
		end else if (us_en) begin
			if (frame_end) begin
				frame_cnt <= '0;
				for (int i = 0; i < 4; i++) begin
					width_q[i] <= 12'(`PWM_MIN_US) + 12'(rate_in[i]);
				end
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// High from frame start for the latched width
	assign motor_1_pwm = (frame_cnt < width_q[0]);
	assign motor_2_pwm = (frame_cnt < width_q[1]);
	assign motor_3_pwm = (frame_cnt < width_q[2]);
	assign motor_4_pwm = (frame_cnt < width_q[3]);

endmodule

/* hw/motor_mixer.sv */
////////////////////////////////////////////////////////////////////////////
// Quad-X layout, commands update 1 cycle after bf_done
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module motor_mixer (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    bf_done, // Load strobe
	input  flight_pkg::rate_t       throttle_rate,
	input  flight_pkg::pid_rate_t   roll_rate,
	input  flight_pkg::pid_rate_t   pitch_rate,
	input  flight_pkg::pid_rate_t   yaw_rate,
	output flight_pkg::motor_rate_t motor_1_rate,
	output flight_pkg::motor_rate_t motor_2_rate,
	output flight_pkg::motor_rate_t motor_3_rate,
	output flight_pkg::motor_rate_t motor_4_rate
);

	logic signed [17:0] thr, roll, pitch, yaw; // Widened so sums never wrap
	logic signed [17:0] sum_1, sum_2, sum_3, sum_4;

	function automatic flight_pkg::motor_rate_t clamp_motor(input logic signed [17:0] v);
		if (v < 18'sd0) return '0;
		if (v > 18'(`MOTOR_MAX)) return 11'(`MOTOR_MAX);
		return v[10:0];
	endfunction

	always_comb begin
		thr   = 18'(throttle_rate);
		roll  = 18'(roll_rate);
		pitch = 18'(pitch_rate);
		yaw   = 18'(yaw_rate);
		sum_1 = thr + pitch - roll - yaw; // Front right, CCW
		sum_2 = thr - pitch + roll - yaw; // Rear left
		sum_3 = thr + pitch + roll + yaw; // Front left, CW
		sum_4 = thr - pitch - roll + yaw; // Rear right
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
		end else if (bf_done) begin
			motor_1_rate <= clamp_motor(sum_1);
			motor_2_rate <= clamp_motor(sum_2);
			motor_3_rate <= clamp_motor(sum_3);
			motor_4_rate <= clamp_motor(sum_4);
		end
	end

endmodule

/* hw/body_frame_controller.sv */
////////////////////////////////////////////////////////////////////////////
// bf_done 4 cycles after ac_done, targets must hold through the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module body_frame_controller (
	input  logic                  sys_clk,
	input  logic                  resetn,
	input  logic                  ac_done, // Start strobe
	input  flight_pkg::rate_t     roll_target,
	input  flight_pkg::rate_t     pitch_target,
	input  flight_pkg::rate_t     yaw_target,
	input  flight_pkg::rate_t     roll_angle_error,
	input  flight_pkg::rate_t     pitch_angle_error,
	input  flight_pkg::imu_val_t  gyro_roll,
	input  flight_pkg::imu_val_t  gyro_pitch,
	input  flight_pkg::imu_val_t  gyro_yaw,
	output flight_pkg::pid_rate_t roll_rate,
	output flight_pkg::pid_rate_t pitch_rate,
	output flight_pkg::pid_rate_t yaw_rate,
	output logic                  bf_done
);

	flight_pkg::ctrl_state_t state;
	flight_pkg::imu_val_t gyro_roll_q, gyro_pitch_q, gyro_yaw_q;
	flight_pkg::pid_rate_t roll_w, pitch_w; // Held until publish
	flight_pkg::rate_t tgt_sel, err_sel;
	flight_pkg::imu_val_t gyro_sel;
	logic signed [17:0] sum_wide; // Worst case about 43000, no wrap
	flight_pkg::pid_rate_t sum_sat;

	function automatic flight_pkg::pid_rate_t sat_pid(input logic signed [17:0] v);
		if (v > 18'sd2047) return 12'sh7ff;
		if (v < -18'sd2048) return 12'sh800;
		return v[11:0];
	endfunction

	// Shared adder, target - gyro/16 + error/4
	always_comb begin
		tgt_sel  = roll_target; // Angle stage holds these until its next done
		err_sel  = roll_angle_error;
		gyro_sel = gyro_roll_q;
		case (state)
			flight_pkg::axis_pitch: begin
				tgt_sel  = pitch_target;
				err_sel  = pitch_angle_error;
				gyro_sel = gyro_pitch_q;
			end
			flight_pkg::axis_yaw: begin
				tgt_sel  = yaw_target;
				err_sel  = '0; // No angle term on yaw
				gyro_sel = gyro_yaw_q;
			end
			default: ;
		endcase
		sum_wide = 18'(tgt_sel) - 18'(gyro_sel >>> 4) + 18'(err_sel >>> 2);
		sum_sat  = sat_pid(sum_wide);
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state      <= flight_pkg::idle;
			roll_rate  <= '0;
			pitch_rate <= '0;
			yaw_rate   <= '0;
		end else begin
			case (state)
				flight_pkg::idle: if (ac_done) state <= flight_pkg::axis_roll;
				flight_pkg::axis_roll: state <= flight_pkg::axis_pitch;
				flight_pkg::axis_pitch: state <= flight_pkg::axis_yaw;
				flight_pkg::axis_yaw: state <= flight_pkg::done;
				default: state <= flight_pkg::idle;
			endcase
			if (state == flight_pkg::axis_yaw) begin // Publish all three at once
				roll_rate  <= roll_w;
				pitch_rate <= pitch_w;
				yaw_rate   <= sum_sat;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == flight_pkg::idle && ac_done) begin // Gyro sample at start
			gyro_roll_q  <= gyro_roll;
			gyro_pitch_q <= gyro_pitch;
			gyro_yaw_q   <= gyro_yaw;
		end
		if (state == flight_pkg::axis_roll) roll_w <= sum_sat;
		if (state == flight_pkg::axis_pitch) pitch_w <= sum_sat;
	end

	assign bf_done = (state == flight_pkg::done);

endmodule

/* hw/angle_controller.sv */
////////////////////////////////////////////////////////////////////////////
// ac_done 4 cycles after imu_valid, new starts ignored while busy
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module angle_controller (
	input  logic                 sys_clk,
	input  logic                 resetn,
	input  logic                 imu_valid, // Start strobe
	input  flight_pkg::rc_val_t  throttle_val,
	input  flight_pkg::rc_val_t  yaw_val,
	input  flight_pkg::rc_val_t  roll_val,
	input  flight_pkg::rc_val_t  pitch_val,
	input  flight_pkg::imu_val_t euler_roll,
	input  flight_pkg::imu_val_t euler_pitch,
	output flight_pkg::rate_t    throttle_rate,
	output flight_pkg::rate_t    roll_target,
	output flight_pkg::rate_t    pitch_target,
	output flight_pkg::rate_t    yaw_target,
	output flight_pkg::rate_t    roll_angle_error,
	output flight_pkg::rate_t    pitch_angle_error,
	output logic                 ac_done
);

	flight_pkg::ctrl_state_t state;
	flight_pkg::rc_val_t thr_q, yaw_q, roll_q, pitch_q; // Sample taken at start
	flight_pkg::imu_val_t eul_roll_q, eul_pitch_q;
	flight_pkg::rate_t roll_err_w, roll_tgt_w; // Held until publish
	flight_pkg::rate_t pitch_err_w, pitch_tgt_w;
	flight_pkg::rc_val_t stick_sel; // Shared path operands
	flight_pkg::imu_val_t euler_sel;
	logic signed [17:0] err_wide;
	logic signed [20:0] tgt_wide;
	flight_pkg::rate_t err_sat, tgt_sat;

	function automatic flight_pkg::rate_t sat_rate(input logic signed [20:0] v);
		if (v > 21'sd32767) return 16'sh7fff;
		if (v < -21'sd32768) return 16'sh8000;
		return v[15:0];
	endfunction

	// One subtract and shift path, operands picked by the current axis
	always_comb begin
		stick_sel = roll_q;
		euler_sel = eul_roll_q;
		case (state)
			flight_pkg::axis_pitch: begin
				stick_sel = pitch_q;
				euler_sel = eul_pitch_q;
			end
			flight_pkg::axis_yaw: begin
				stick_sel = yaw_q;
				euler_sel = '0; // Yaw holds rate only, no angle
			end
			default: ;
		endcase
		err_wide = $signed({10'b0, stick_sel}) - 18'(`RC_CENTER) - 18'(euler_sel >>> 4);
		if (state == flight_pkg::axis_yaw) begin
			tgt_wide = 21'(err_wide) <<< `YAW_GAIN_SHIFT;
		end else begin
			tgt_wide = 21'(err_wide) <<< `ANGLE_GAIN_SHIFT;
		end
		err_sat = sat_rate(21'(err_wide));
		tgt_sat = sat_rate(tgt_wide);
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state             <= flight_pkg::idle;
			throttle_rate     <= '0;
			roll_target       <= '0;
			pitch_target      <= '0;
			yaw_target        <= '0;
			roll_angle_error  <= '0;
			pitch_angle_error <= '0;
		end else begin
			case (state)
				flight_pkg::idle: if (imu_valid) state <= flight_pkg::axis_roll;
				flight_pkg::axis_roll: state <= flight_pkg::axis_pitch;
				flight_pkg::axis_pitch: state <= flight_pkg::axis_yaw;
				flight_pkg::axis_yaw: state <= flight_pkg::done;
				default: state <= flight_pkg::idle; // done lasts one cycle
			endcase
			// All outputs change together, just before done
			if (state == flight_pkg::axis_yaw) begin
				throttle_rate     <= flight_pkg::rate_t'({6'b0, thr_q, 2'b00}); // x4
				roll_target       <= roll_tgt_w;
				pitch_target      <= pitch_tgt_w;
				yaw_target        <= tgt_sat;
				roll_angle_error  <= roll_err_w;
				pitch_angle_error <= pitch_err_w;
			end
		end
	end

	// Input sample and per-axis working values
	always_ff @(posedge sys_clk) begin
		if (state == flight_pkg::idle && imu_valid) begin
			thr_q       <= throttle_val;
			yaw_q       <= yaw_val;
			roll_q      <= roll_val;
			pitch_q     <= pitch_val;
			eul_roll_q  <= euler_roll;
			eul_pitch_q <= euler_pitch;
		end
		if (state == flight_pkg::axis_roll) begin
			roll_err_w <= err_sat;
			roll_tgt_w <= tgt_sat;
		end
		if (state == flight_pkg::axis_pitch) begin
			pitch_err_w <= err_sat;
			pitch_tgt_w <= tgt_sat;
		end
	end

	assign ac_done = (state == flight_pkg::done);

endmodule

/* hw/receiver.sv */
////////////////////////////////////////////////////////////////////////////
// Value lands 3 cycles after the falling edge, widths count to 4095 us
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module receiver (
	input  logic                sys_clk,
	input  logic                resetn,
	input  logic                us_en,
	input  logic                throttle_pwm,
	input  logic                yaw_pwm,
	input  logic                roll_pwm,
	input  logic                pitch_pwm,
	output flight_pkg::rc_val_t throttle_val,
	output flight_pkg::rc_val_t yaw_val,
	output flight_pkg::rc_val_t roll_val,
	output flight_pkg::rc_val_t pitch_val
);

	logic [3:0] pwm_in;
	logic [3:0] sync_1; // First synchronizer stage
	logic [3:0] sync_2; // Second stage, safe to use
	logic [3:0] sync_3; // Previous sync_2 for edge detection
	pulse_pkg::pulse_us_t width_cnt [4];
	flight_pkg::rc_val_t stick_q [4];

	// (width - 1000) / 4, clamped to 0..255
	function automatic flight_pkg::rc_val_t to_stick(input pulse_pkg::pulse_us_t width);
		pulse_pkg::pulse_us_t offset;
		if (width < 12'(`RC_MIN_US)) return '0; // Short pulse reads as zero stick
		offset = (width - 12'(`RC_MIN_US)) >> 2;
		if (offset > 12'd255) return 8'd255;
		return offset[7:0];
	endfunction

	assign pwm_in = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
		end
	end

	for (genvar ch = 0; ch < 4; ch++) begin : g_ch
		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				width_cnt[ch] <= '0;
				stick_q[ch]   <= '0;
			end else begin
				if (sync_3[ch] && !sync_2[ch]) begin // Falling edge
					stick_q[ch] <= to_stick(width_cnt[ch]);
				end
				if (!sync_2[ch]) begin
					width_cnt[ch] <= '0; // Idle low, ready for the next pulse
				end else if (us_en && width_cnt[ch] != '1) begin
					width_cnt[ch] <= width_cnt[ch] + 1'b1; // Stops at the top
				end
			end
		end
	end

	assign throttle_val = stick_q[0];
	assign yaw_val      = stick_q[1];
	assign roll_val     = stick_q[2];
	assign pitch_val    = stick_q[3];

endmodule

/* hw/us_tick.sv */
////////////////////////////////////////////////////////////////////////////
// Needs CLK_PER_US of 2 or more
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "flight_macros.svh"

module us_tick (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_en // One cycle high per microsecond
);

	localparam int CNT_W = $clog2(`CLK_PER_US);

	logic [CNT_W-1:0] cyc_cnt;

	// Tick on the last cycle of each microsecond
	assign us_en = (cyc_cnt == CNT_W'(`CLK_PER_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			cyc_cnt <= '0;
		end else if (us_en) begin
			cyc_cnt <= '0; // Wrap
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

endmodule

/* hw/pulse_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Pulse widths up to 4095 us, enough for RC and ESC frames
////////////////////////////////////////////////////////////////////////////
package pulse_pkg;

	// Microsecond count for pulse widths and the ESC frame position
	typedef logic [11:0] pulse_us_t;

endpackage

/* hw/flight_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// IMU values are 16 LSB per degree or per degree per second
////////////////////////////////////////////////////////////////////////////
package flight_pkg;

	// Stick value from the receiver, 0..255, center 128
	typedef logic [7:0] rc_val_t;

	// Raw IMU reading, euler angle or gyro rate
	typedef logic signed [15:0] imu_val_t;

	typedef logic signed [15:0] rate_t; // Target rate or angle error
	typedef logic signed [11:0] pid_rate_t; // Axis correction into the mixer
	typedef logic [10:0] motor_rate_t; // Motor command, 0..MOTOR_MAX

	// Shared by both controllers, one axis per state
	typedef enum logic [2:0] {
		idle,
		axis_roll,
		axis_pitch,
		axis_yaw,
		done
	} ctrl_state_t;

endpackage

/* include/flight_macros.svh */
////////////////////////////////////////////////////////////////////////////
// Timing constants assume sys_clk is a whole number of MHz, at least 2 MHz
////////////////////////////////////////////////////////////////////////////
`ifndef FLIGHT_MACROS_SVH
`define FLIGHT_MACROS_SVH

// Clocking
`define CLK_PER_US 10 // sys_clk cycles per microsecond

// Receiver scaling
`define RC_MIN_US 1000 // Pulse width that reads as stick 0
`define RC_CENTER 128 // Stick value at center

// Controller gains, as left shifts
`define ANGLE_GAIN_SHIFT 2 // Angle error to target rate
`define YAW_GAIN_SHIFT 1 // Yaw stick offset to yaw rate

// Motor and ESC output
`define MOTOR_MAX 1000 // Highest motor command
`define PWM_MIN_US 1000 // ESC pulse for command 0
`define PWM_FRAME_US 2500 // ESC frame period in us

`endif
